// ==== tb.f ====
logic/pager_pkg.sv
logic/pte_pkg.sv
logic/ptbr_regs.sv
logic/walk_fsm.sv
logic/level_counter.sv
logic/walk_addr_gen.sv
logic/fill_builder.sv
logic/pager_top.sv
test/pager_props.sv
test/pager_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the page-table walker testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert --top-module pager_tb -f tb.f -o pager_sim \
  > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/pager_sim > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log

grep -q "Verification failed" sim.log && exit 1
grep -q "Verification passed" sim.log && exit 0 || exit 1

// ==== test/pager_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module pager_tb
  import pager_pkg::*;
();

  localparam int WALKS       = 18;
  localparam int CYCLE_LIMIT = 40 * WALKS + 60;

  logic        clk;
  logic        rst;
  walk_req_t   walk_req;
  logic        req_valid;
  logic        req_ready;
  csr_wr_t     csr_wr;
  logic        csr_en;
  mem_req_t    mem_req;
  logic        mem_req_valid;
  logic        mem_req_ready = 1'b0;
  logic [31:0] mem_rsp_data  = '0;
  logic        mem_rsp_valid = 1'b0;
  fill_t       fill;
  logic        fill_valid;

  // sparse page-table words by byte address
  logic [31:0] pt_mem [logic [31:0]];
  logic [19:0] root0 = '0;
  logic [19:0] root1 = '0;
  logic        paging = 1'b0;
  fill_t       exp_q[$];
  int          reads_q[$];
  logic        ident_q[$];

  int          cycle = 0;
  int          accept_cycle = 0;
  int          accept_cnt = 0;
  int          fill_cnt = 0;
  int          reads = 0;
  int          errors = 0;
  int          reset_errors = 0;
  int          mem_acc_cnt = 0;
  int          mem_seen = 0;
  logic [31:0] taken_addr = '0;
  logic        rd_busy = 1'b0;
  logic [31:0] rd_addr = '0;
  int          rd_delay = 0;

  pager_top dut_i (
    .clk           (clk),
    .rst           (rst),
    .walk_req      (walk_req),
    .req_valid     (req_valid),
    .req_ready     (req_ready),
    .csr_wr        (csr_wr),
    .csr_en        (csr_en),
    .mem_req       (mem_req),
    .mem_req_valid (mem_req_valid),
    .mem_req_ready (mem_req_ready),
    .mem_rsp_data  (mem_rsp_data),
    .mem_rsp_valid (mem_rsp_valid),
    .fill          (fill),
    .fill_valid    (fill_valid)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] entry_addr(input logic [19:0] frame, input logic [8:0] idx);
    return {frame, 12'h000} + {21'd0, idx, 2'b00};
  endfunction

  function automatic logic [31:0] ptr_word(input logic [19:0] frame);
    return {frame, 10'd0, 1'b0, 1'b1};
  endfunction

  // flags are dirty, accessed, global, system, writable from the top
  function automatic logic [31:0] leaf_word(input logic [19:0] frame, input logic [4:0] flags);
    return {frame, 5'd0, flags, 2'b11};
  endfunction

  function automatic logic [38:0] make_va(input logic [8:0] i2, input logic [8:0] i1,
                                          input logic [8:0] i0, input logic [11:0] off);
    return {i2, i1, i0, off};
  endfunction

  function automatic logic [31:0] read_word(input logic [31:0] addr);
    if (pt_mem.exists(addr)) begin
      return pt_mem[addr];
    end
    return '0;
  endfunction

  // reference walk over the testbench's own tables
  function automatic fill_t expect_fill(input logic [38:0] va, input logic code,
                                        output int n);
    fill_t       f;
    logic [19:0] frame;
    logic [31:0] word;
    int          lvl;
    logic        done;
    f = '0;
    f.vpn = va[38:12];
    f.code = code;
    n = 0;
    done = !paging;
    if (!paging) begin
      f.ppn = va[31:12];
      f.writable = 1'b1;
      f.accessed = 1'b1;
      f.dirty = 1'b1;
    end
    frame = va[38] ? root1 : root0;
    lvl = 2;
    while (!done) begin
      word = read_word(entry_addr(frame, va[12 + 9 * lvl +: 9]));
      n++;
      done = 1'b1;
      if (!word[0] || (!word[1] && lvl == 0)) begin
        f.fault = 1'b1;
      end else if (word[1]) begin
        f.ppn = word[31:12];
        if (lvl == 2) begin
          f.ppn[17:0] = va[29:12];
        end else if (lvl == 1) begin
          f.ppn[8:0] = va[20:12];
        end
        f.size = 2'(lvl);
        f.writable = word[2];
        f.system = word[3];
        f.glob = word[4];
        f.accessed = word[5];
        f.dirty = word[6];
      end else begin
        frame = word[31:12];
        lvl--;
        done = 1'b0;
      end
    end
    return f;
  endfunction

  task automatic csr_write(input logic [11:0] num, input logic [31:0] data);
    csr_wr.num = num;
    csr_wr.data = data;
    csr_en = 1'b1;
    @(negedge clk);
    csr_en = 1'b0;
    if (num == CSR_ROOT0 || num == CSR_ROOT1) begin
      paging = 1'b1;
    end
    if (num == CSR_ROOT0) begin
      root0 = data[31:12];
    end else if (num == CSR_ROOT1) begin
      root1 = data[31:12];
    end else if (num == CSR_PAGING) begin
      paging = data[0];
    end
  endtask

  task automatic run_walk(input logic [38:0] va, input logic code);
    fill_t f;
    int    n;
    int    acc;
    int    done_cnt;
    f = expect_fill(va, code, n);
    exp_q.push_back(f);
    reads_q.push_back(n);
    ident_q.push_back(!paging);
    acc = accept_cnt;
    done_cnt = fill_cnt;
    walk_req.va = va;
    walk_req.code = code;
    req_valid = 1'b1;
    while (accept_cnt == acc) @(negedge clk);
    req_valid = 1'b0;
    while (fill_cnt == done_cnt) @(negedge clk);
  endtask

  task automatic build_tables();
    pt_mem[entry_addr(20'h00100, 9'd1)] = ptr_word(20'h00110);
    pt_mem[entry_addr(20'h00110, 9'd2)] = ptr_word(20'h00120);
    pt_mem[entry_addr(20'h00120, 9'd3)] = leaf_word(20'h3a5c7, 5'b01011);
    pt_mem[entry_addr(20'h00120, 9'd11)] = ptr_word(20'h00130);
    // huge leaves with junk low frame bits
    pt_mem[entry_addr(20'h00100, 9'd4)] = leaf_word(20'h4c3ff, 5'b11110);
    pt_mem[entry_addr(20'h00110, 9'd9)] = leaf_word(20'h81e55, 5'b00101);
    // upper half of the va space
    pt_mem[entry_addr(20'h00200, 9'h1f0)] = ptr_word(20'h00210);
    pt_mem[entry_addr(20'h00210, 9'd5)] = ptr_word(20'h00220);
    pt_mem[entry_addr(20'h00220, 9'd7)] = leaf_word(20'h5d0e1, 5'b10111);
  endtask

  // checks on the rising edge before outputs update
  always @(posedge clk) begin : monitor
    fill_t exp;
    cycle++;
    if (!rst) begin
      if (req_valid && req_ready) begin
        accept_cycle = cycle;
        accept_cnt++;
        reads = 0;
      end
      if (mem_req_valid && mem_req_ready) begin
        reads++;
        taken_addr = mem_req.addr;
        mem_acc_cnt++;
      end
      if (fill_valid) begin
        if (fill_cnt >= exp_q.size()) begin
          errors++;
          $display("fill at %0t with no walk outstanding", $time);
        end else begin
          exp = exp_q[fill_cnt];
          assert (fill == exp)
            else begin
              errors++;
              $display("MISMATCH at %0t: fill %h, expected %h", $time, fill, exp);
            end
          assert (reads == reads_q[fill_cnt])
            else begin
              errors++;
              $display("MISMATCH at %0t: %0d memory reads, expected %0d", $time, reads,
                       reads_q[fill_cnt]);
            end
          assert (!ident_q[fill_cnt] || cycle == accept_cycle + 1)
            else begin
              errors++;
              $display("MISMATCH at %0t: identity fill %0d cycles after acceptance", $time,
                       cycle - accept_cycle);
            end
        end
        fill_cnt++;
      end
    end
  end

  // page-table memory with random stalls and reply delay
  always @(negedge clk) begin
    mem_rsp_valid = 1'b0;
    if (mem_seen != mem_acc_cnt) begin
      mem_seen = mem_acc_cnt;
      rd_busy = 1'b1;
      rd_addr = taken_addr;
      rd_delay = $urandom_range(3, 0);
    end
    if (rd_busy) begin
      if (rd_delay == 0) begin
        mem_rsp_valid = 1'b1;
        mem_rsp_data = read_word(rd_addr);
        rd_busy = 1'b0;
      end else begin
        rd_delay--;
      end
    end
    mem_req_ready = ($urandom_range(2, 0) != 0);
  end

  initial begin : watchdog
    wait (cycle >= CYCLE_LIMIT);
    $display("timeout: walks still pending after %0d cycles", cycle);
    $display("Verification failed");
    $finish;
  end

  initial begin : stimulus
    logic [38:0] va;
    int          sel;
    void'($urandom(32'had231e1a));
    rst = 1'b1;
    req_valid = 1'b0;
    walk_req = '0;
    csr_en = 1'b0;
    csr_wr = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    assert (req_ready && !fill_valid && !mem_req_valid)
      else begin
        reset_errors++;
        $display("MISMATCH at %0t: handshake outputs wrong after reset", $time);
      end

    // paging still off after reset
    run_walk(39'h12_3456_7abc, 1'b1);
    run_walk(39'h7f_fedc_b123, 1'b0);

    build_tables();
    csr_write(CSR_ROOT1, 32'h0020_0abc);
    csr_write(CSR_ROOT0, 32'h0010_0000);
    run_walk(make_va(9'd1, 9'd2, 9'd3, 12'h123), 1'b0);
    run_walk(make_va(9'h1f0, 9'd5, 9'd7, 12'hfed), 1'b1);
    run_walk(make_va(9'd4, 9'h15a, 9'h0c3, 12'h456), 1'b0);
    run_walk(make_va(9'd1, 9'd9, 9'h1a5, 12'h789), 1'b1);
    run_walk(make_va(9'd7, 9'd0, 9'd0, 12'h000), 1'b0);
    run_walk(make_va(9'd1, 9'd2, 9'd10, 12'h000), 1'b0);
    run_walk(make_va(9'd1, 9'd2, 9'd11, 12'h000), 1'b1);

    for (int i = 0; i < 8; i++) begin
      va = {7'($urandom()), 32'($urandom())};
      sel = $urandom_range(3, 0);
      case (sel)
        0: va[38:30] = 9'd1;
        1: va[38:30] = 9'd4;
        2: va[38:30] = 9'h1f0;
        default: va[38:30] = 9'd7;
      endcase
      run_walk(va, 1'($urandom()));
    end

    csr_write(CSR_PAGING, 32'h0000_0000);
    run_walk(make_va(9'h0a1, 9'd3, 9'd77, 12'h321), 1'b1);

    repeat (3) @(negedge clk);
    $display("fills checked %0d, fill errors %0d, reset errors %0d, protocol errors %0d",
             fill_cnt, errors, reset_errors, dut_i.props_i.fail_cnt);
    if (errors == 0 && reset_errors == 0 && dut_i.props_i.fail_cnt == 0 &&
        fill_cnt == WALKS) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/pager_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module pager_props
  import pager_pkg::*;
(
  input logic     clk,
  input logic     rst,
  input logic     req_valid,
  input logic     req_ready,
  input mem_req_t mem_req,
  input logic     mem_req_valid,
  input logic     mem_req_ready,
  input logic     fill_valid
);

  int fail_cnt = 0;

  // stalled read keeps its address
  mem_req_held: assert property (@(posedge clk) disable iff (rst)
    mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
    else begin
      fail_cnt++;
      $error("memory request changed or dropped while stalled");
    end

  fill_single: assert property (@(posedge clk) disable iff (rst)
    fill_valid |=> !fill_valid)
    else begin
      fail_cnt++;
      $error("fill valid high on two cycles in a row");
    end

  busy_after_accept: assert property (@(posedge clk) disable iff (rst)
    req_valid && req_ready |=> !req_ready)
    else begin
      fail_cnt++;
      $error("walker ready again right after acceptance");
    end

  // ready only comes back after a fill
  busy_until_fill: assert property (@(posedge clk) disable iff (rst)
    !req_ready && !fill_valid |=> !req_ready)
    else begin
      fail_cnt++;
      $error("walker ready again before its fill");
    end

  no_read_idle: assert property (@(posedge clk) disable iff (rst)
    req_ready |-> !mem_req_valid)
    else begin
      fail_cnt++;
      $error("memory read issued while the walker is idle");
    end

endmodule

bind pager_top pager_props props_i (
  .clk           (clk),
  .rst           (rst),
  .req_valid     (req_valid),
  .req_ready     (req_ready),
  .mem_req       (mem_req),
  .mem_req_valid (mem_req_valid),
  .mem_req_ready (mem_req_ready),
  .fill_valid    (fill_valid)
);

`default_nettype wire

// ==== logic/pager_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module pager_top
  import pager_pkg::*;
  import pte_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  walk_req_t   walk_req,
  input  logic        req_valid,
  output logic        req_ready,
  input  csr_wr_t     csr_wr,
  input  logic        csr_en,
  output mem_req_t    mem_req,
  output logic        mem_req_valid,
  input  logic        mem_req_ready,
  input  logic [31:0] mem_rsp_data,
  input  logic        mem_rsp_valid,
  output fill_t       fill,
  output logic        fill_valid
);

  logic [31:0] root;
  logic        paging_on;
  logic        load;
  logic        step;
  logic        capture;
  logic        identity;
  logic        last;
  level_t      level;
  walk_req_t   held_req;
  pte_u        rsp_pte;

  assign rsp_pte = pte_u'(mem_rsp_data);

  ptbr_regs u_ptbr_regs (
    .clk       (clk),
    .rst       (rst),
    .csr_en    (csr_en),
    .csr_wr    (csr_wr),
    .root_sel  (walk_req.va[VA_WIDTH-1]),
    .root      (root),
    .paging_on (paging_on)
  );

  walk_fsm u_walk_fsm (
    .clk           (clk),
    .rst           (rst),
    .req_valid     (req_valid),
    .req_ready     (req_ready),
    .paging_on     (paging_on),
    .mem_req_valid (mem_req_valid),
    .mem_req_ready (mem_req_ready),
    .mem_rsp_valid (mem_rsp_valid),
    .pte           (rsp_pte),
    .last          (last),
    .load          (load),
    .step          (step),
    .capture       (capture),
    .identity      (identity),
    .fill_valid    (fill_valid)
  );

  level_counter u_level_counter (
    .clk   (clk),
    .rst   (rst),
    .load  (load),
    .step  (step),
    .level (level),
    .last  (last)
  );

  walk_addr_gen u_walk_addr_gen (
    .clk        (clk),
    .rst        (rst),
    .load       (load),
    .step       (step),
    .req_in     (walk_req),
    .root       (root),
    .level      (level),
    .next_frame (rsp_pte.ptr.frame),
    .held_req   (held_req),
    .mem_req    (mem_req)
  );

  fill_builder u_fill_builder (
    .clk      (clk),
    .rst      (rst),
    .capture  (capture),
    .identity (identity),
    .pte      (rsp_pte),
    .level    (level),
    .held_req (held_req),
    .fill     (fill)
  );

endmodule

`default_nettype wire

// ==== logic/fill_builder.sv ====
`timescale 1ns/1ps
`default_nettype none

module fill_builder
  import pager_pkg::*;
  import pte_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      capture,
  input  logic      identity,
  input  pte_u      pte,
  input  level_t    level,
  input  walk_req_t held_req,
  output fill_t     fill
);

  logic                           ident_q;
  logic                           fault_q;
  pte_leaf_t                      page_q;
  level_t                         level_q;
  logic [PA_WIDTH-PAGE_SHIFT-1:0] ppn;

  always_ff @(posedge clk) begin
    if (rst) begin
      ident_q <= 1'b0;
      fault_q <= 1'b0;
    end else if (capture) begin
      ident_q <= identity;
      fault_q <= !identity && !(pte.page.valid && pte.page.leaf);
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      page_q  <= pte.page;
      level_q <= level;
    end
  end

  // huge pages keep the va bits below their size
  always_comb begin
    ppn = page_q.frame;
    if (level_q == level_t'(2)) begin
      ppn[2*IDX_WIDTH-1:0] = held_req.va[PAGE_SHIFT +: 2*IDX_WIDTH];
    end else if (level_q == level_t'(1)) begin
      ppn[IDX_WIDTH-1:0] = held_req.va[PAGE_SHIFT +: IDX_WIDTH];
    end
  end

  always_comb begin
    fill = '0;
    // vpn and target stay so a fault lands in the right TLB
    fill.vpn  = held_req.va[VA_WIDTH-1:PAGE_SHIFT];
    fill.code = held_req.code;
    if (ident_q) begin
      fill.ppn      = held_req.va[PA_WIDTH-1:PAGE_SHIFT];
      fill.size     = SIZE_4K;
      fill.writable = 1'b1;
      fill.accessed = 1'b1;
      fill.dirty    = 1'b1;
    end else if (fault_q) begin
      fill.fault = 1'b1;
    end else begin
      fill.ppn = ppn;
      case (level_q)
        level_t'(0): fill.size = SIZE_4K;
        level_t'(1): fill.size = SIZE_2M;
        default:     fill.size = SIZE_1G;
      endcase
      fill.writable = page_q.writable;
      fill.system   = page_q.system;
      fill.glob     = page_q.glob;
      fill.accessed = page_q.accessed;
      fill.dirty    = page_q.dirty;
    end
  end

endmodule

`default_nettype wire

// ==== logic/walk_addr_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module walk_addr_gen
  import pager_pkg::*;
  import pte_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        load,
  input  logic        step,
  input  walk_req_t   req_in,
  input  logic [31:0] root,
  input  level_t      level,
  input  logic [19:0] next_frame,
  output walk_req_t   held_req,
  output mem_req_t    mem_req
);

  logic [PA_WIDTH-PAGE_SHIFT-1:0] table_frame;
  logic [IDX_WIDTH-1:0]           idx;

  // frame of the table being read
  always_ff @(posedge clk) begin
    if (rst) begin
      table_frame <= '0;
    end else if (load) begin
      table_frame <= root[PA_WIDTH-1:PAGE_SHIFT];
    end else if (step) begin
      table_frame <= next_frame;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      held_req <= req_in;
    end
  end

  // 9 va bits per level above the page offset
  assign idx = held_req.va[PAGE_SHIFT + IDX_WIDTH * int'(level) +: IDX_WIDTH];

  // 512 entries of 4 bytes fill the low half of the table frame
  assign mem_req.addr = {table_frame, 1'b0, idx, 2'b00};

endmodule

`default_nettype wire

// ==== logic/level_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module level_counter
  import pte_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  logic   load,
  input  logic   step,
  output level_t level,
  output logic   last
);

  // walk starts at the top table and stops where the leaf was found
  always_ff @(posedge clk) begin
    if (rst) begin
      level <= '0;
    end else if (load) begin
      level <= level_t'(LEVELS - 1);
    end else if (step && !last) begin
      level <= level - level_t'(1);
    end
  end

  // bottom table maps 4K pages
  assign last = (level == '0);

endmodule

`default_nettype wire

// ==== logic/walk_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module walk_fsm
  import pte_pkg::*;
(
  input  logic clk,
  input  logic rst,
  input  logic req_valid,
  output logic req_ready,
  input  logic paging_on,
  output logic mem_req_valid,
  input  logic mem_req_ready,
  input  logic mem_rsp_valid,
  input  pte_u pte,
  input  logic last,
  output logic load,
  output logic step,
  output logic capture,
  output logic identity,
  output logic fill_valid
);

  typedef enum logic [1:0] {
    s_idle,
    s_issue,
    s_wait,
    s_finish
  } state_t;

  state_t state;
  state_t state_nxt;
  logic   accept;
  logic   is_ptr;

  assign accept = req_valid && req_ready;

  // only a valid non-leaf entry descends
  assign is_ptr = pte.ptr.valid && !pte.ptr.leaf;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= s_idle;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    step      = 1'b0;
    capture   = 1'b0;
    case (state)
      s_idle: begin
        if (accept) begin
          // identity fill is taken straight from the request
          capture   = !paging_on;
          state_nxt = paging_on ? s_issue : s_finish;
        end
      end
      s_issue: begin
        if (mem_req_ready) begin
          state_nxt = s_wait;
        end
      end
      s_wait: begin
        if (mem_rsp_valid) begin
          if (is_ptr && !last) begin
            step      = 1'b1;
            state_nxt = s_issue;
          end else begin
            // leaf, invalid, or pointer off the bottom
            capture   = 1'b1;
            state_nxt = s_finish;
          end
        end
      end
      s_finish: begin
        state_nxt = s_idle;
      end
      default: begin
        state_nxt = s_idle;
      end
    endcase
  end

  assign req_ready     = (state == s_idle);
  assign load          = accept;
  assign identity      = (state == s_idle) && !paging_on;
  assign mem_req_valid = (state == s_issue);
  assign fill_valid    = (state == s_finish);

endmodule

`default_nettype wire

// ==== logic/ptbr_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module ptbr_regs
  import pager_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        csr_en,
  input  csr_wr_t     csr_wr,
  input  logic        root_sel,
  output logic [31:0] root,
  output logic        paging_on
);

  logic [PA_WIDTH-13:0] root0_frame;
  logic [PA_WIDTH-13:0] root1_frame;

  always_ff @(posedge clk) begin
    if (rst) begin
      root0_frame <= '0;
      root1_frame <= '0;
      paging_on   <= 1'b0;
    end else if (csr_en) begin
      case (csr_wr.num)
        CSR_ROOT0: begin
          root0_frame <= csr_wr.data[PA_WIDTH-1:12];
          paging_on   <= 1'b1;
        end
        CSR_ROOT1: begin
          root1_frame <= csr_wr.data[PA_WIDTH-1:12];
          paging_on   <= 1'b1;
        end
        CSR_PAGING: begin
          paging_on <= csr_wr.data[0];
        end
        default: begin
        end
      endcase
    end
  end

  // upper half of the va space walks from root 1
  assign root = {(root_sel ? root1_frame : root0_frame), 12'h000};

endmodule

`default_nettype wire

// ==== logic/pte_pkg.sv ====
`default_nettype none

package pte_pkg;

  localparam int LEVELS     = 3;
  localparam int IDX_WIDTH  = 9;
  localparam int PAGE_SHIFT = 12;

  typedef logic [1:0] level_t;

  // entry pointing at the next table down
  typedef struct packed {
    logic [19:0] frame;
    logic [9:0]  rsvd;
    logic        leaf;
    logic        valid;
  } pte_ptr_t;

  // entry mapping a page, leaf bit set
  typedef struct packed {
    logic [19:0] frame;
    logic [4:0]  rsvd;
    logic        dirty;
    logic        accessed;
    logic        glob;
    logic        system;
    logic        writable;
    logic        leaf;
    logic        valid;
  } pte_leaf_t;

  // valid and leaf sit in the same bits in both views
  typedef union packed {
    pte_ptr_t  ptr;
    pte_leaf_t page;
  } pte_u;

endpackage

`default_nettype wire

// ==== logic/pager_pkg.sv ====
`default_nettype none

package pager_pkg;

  localparam int VA_WIDTH = 39;
  localparam int PA_WIDTH = 32;

  // walker control registers
  localparam logic [11:0] CSR_ROOT0  = 12'h5c0;
  localparam logic [11:0] CSR_ROOT1  = 12'h5c1;
  localparam logic [11:0] CSR_PAGING = 12'h5c2;

  // page size codes carried in the fill word
  localparam logic [1:0] SIZE_4K = 2'd0;
  localparam logic [1:0] SIZE_2M = 2'd1;
  localparam logic [1:0] SIZE_1G = 2'd2;

  typedef struct packed {
    logic [VA_WIDTH-1:0] va;
    logic                code;
  } walk_req_t;

  // entry address, always word aligned
  typedef struct packed {
    logic [PA_WIDTH-1:0] addr;
  } mem_req_t;

  typedef struct packed {
    logic [11:0] num;
    logic [31:0] data;
  } csr_wr_t;

  typedef struct packed {
    logic [VA_WIDTH-13:0] vpn;
    logic [PA_WIDTH-13:0] ppn;
    logic [1:0]           size;
    logic                 writable;
    logic                 system;
    logic                 glob;
    logic                 accessed;
    logic                 dirty;
    logic                 fault;
    // set for the instruction TLB
    logic                 code;
  } fill_t;

endpackage

`default_nettype wire
